// File: alu.sv
module alu import isa_pkg::*, ctrl_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output flags_t  flags
);

  word_t        sum, diff;
  logic [3:0]   sh;
  logic [31:0]  rot;
  logic         ovf_add, ovf_sub;

  assign sh   = b[3:0];
  assign sum  = a + b;
  assign diff = a - b;

  // rotate right by shifting a doubled copy
  assign rot = {a, a} >> sh;

  // signed overflow, the sign of the result disagrees with the operands
  assign ovf_add = (a[15] == b[15]) && (sum[15] != a[15]);
  assign ovf_sub = (a[15] != b[15]) && (diff[15] != a[15]);

  always_comb begin
    case (op)
      alu_add: result = sum;
      alu_sub: result = diff;
      alu_xor: result = a ^ b;
      alu_sll: result = a << sh;
      // arithmetic shift keeps the sign
      alu_sra: result = word_t'($signed(a) >>> sh);
      alu_ror: result = rot[15:0];
      // byte loads keep the other half of rd
      alu_llb: result = {a[15:8], b[7:0]};
      alu_lhb: result = {b[7:0], a[7:0]};
      default: result = sum;
    endcase
  end

  // v only means something for add and sub
  always_comb begin
    flags         = '0;
    flags[flag_z] = (result == 16'h0000);
    flags[flag_n] = result[15];
    case (op)
      alu_add: flags[flag_v] = ovf_add;
      alu_sub: flags[flag_v] = ovf_sub;
      default: flags[flag_v] = 1'b0;
    endcase
  end

endmodule

// File: build.f
isa_pkg.sv
ctrl_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
alu.sv
execute_stage.sv
cpu.sv
cpu_tb.sv

// File: cpu.sv
module cpu import isa_pkg::*, ctrl_pkg::*; #(
  parameter word_t reset_pc = 16'h0000
) (
  input  logic  clk,
  input  logic  arst_n,
  input  word_t imem_data,
  input  word_t dmem_rdata,
  output logic  hlt,
  output word_t pc,
  output word_t imem_addr,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_we
);

  // fetch to decode
  logic     if_valid, stop_fetch;
  word_t    if_instr, if_pc, fetch_pc;

  // decode to execute
  logic     id_valid, id_wr_en, id_store, id_load;
  logic     id_branch, id_branch_reg, id_halt;
  alu_op_t  id_op;
  word_t    id_a, id_b, id_imm, id_pc;
  reg_idx_t id_rd;
  wb_sel_t  id_wb_sel;
  flags_t   id_flag_en;
  cond_t    id_cond;

  // execute back to fetch and decode
  logic     redirect, wb_en;
  word_t    redirect_pc, wb_data;
  reg_idx_t wb_idx;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .stop_fetch  (stop_fetch),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_data   (imem_data),
    .imem_addr   (fetch_pc),
    .if_valid    (if_valid),
    .if_instr    (if_instr),
    .if_pc       (if_pc)
  );

  decode_stage u_decode (
    .clk (clk), .arst_n (arst_n),
    .if_valid (if_valid), .if_instr (if_instr), .if_pc (if_pc),
    .redirect (redirect),
    .wb_en (wb_en), .wb_idx (wb_idx), .wb_data (wb_data),
    .stop_fetch (stop_fetch), .id_valid (id_valid), .id_op (id_op),
    .id_a (id_a), .id_b (id_b), .id_imm (id_imm), .id_pc (id_pc),
    .id_rd (id_rd), .id_wb_sel (id_wb_sel), .id_wr_en (id_wr_en),
    .id_store (id_store), .id_load (id_load), .id_flag_en (id_flag_en),
    .id_cond (id_cond), .id_branch (id_branch),
    .id_branch_reg (id_branch_reg), .id_halt (id_halt)
  );

  execute_stage u_execute (
    .clk (clk), .arst_n (arst_n),
    .id_valid (id_valid), .id_op (id_op), .id_a (id_a), .id_b (id_b),
    .id_imm (id_imm), .id_pc (id_pc), .id_rd (id_rd), .id_wb_sel (id_wb_sel),
    .id_wr_en (id_wr_en), .id_store (id_store), .id_load (id_load),
    .id_flag_en (id_flag_en), .id_cond (id_cond), .id_branch (id_branch),
    .id_branch_reg (id_branch_reg), .id_halt (id_halt),
    .dmem_rdata (dmem_rdata),
    .redirect (redirect), .redirect_pc (redirect_pc),
    .wb_en (wb_en), .wb_idx (wb_idx), .wb_data (wb_data),
    .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_we (dmem_we),
    .hlt (hlt)
  );

  // the visible pc is the fetch address
  assign imem_addr = fetch_pc;
  assign pc        = fetch_pc;

endmodule

// File: cpu_tb.sv
module cpu_tb import isa_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_tests = 14;
  localparam int max_words = 16;
  localparam int max_stores = 8;

  logic  clk;
  logic  arst_n;
  word_t imem_data, dmem_rdata;
  logic  hlt, dmem_we;
  word_t pc, imem_addr, dmem_addr, dmem_wdata;

  // memories are 64 words, indexed by the half-word address
  word_t imem [64];
  word_t dmem [64];
  word_t log_addr [$];
  word_t log_data [$];

  // test table
  string name [max_tests];
  word_t prog [max_tests][max_words];
  int    nwords [max_tests];
  word_t exp_addr [max_tests][max_stores];
  word_t exp_data [max_tests][max_stores];
  int    nstores [max_tests];
  word_t exp_pc [max_tests];
  int    ntests;

  word_t rng_state;
  int    cycles;
  int    cycle_limit;
  int    err_count;
  int    pass_count;
  int    fail_count;

  cpu #(.reset_pc(16'h0000)) DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_data  (imem_data),
    .dmem_rdata (dmem_rdata),
    .hlt        (hlt),
    .pc         (pc),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[6:1]];
  assign dmem_rdata = dmem[dmem_addr[6:1]];

  // stores land mid-cycle, when the execute outputs have settled
  always @(negedge clk) begin
    if (arst_n && dmem_we) begin
      dmem[dmem_addr[6:1]] = dmem_wdata;
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: cpu did not halt within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // 16-bit xorshift operand source
  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 7);
    rng_state = rng_state ^ (rng_state >> 9);
    rng_state = rng_state ^ (rng_state << 8);
    return rng_state;
  endfunction

  // encoders, opcode in [15:12]
  function automatic word_t enc(logic [3:0] op, logic [3:0] f1, logic [3:0] f2,
                                logic [3:0] f3);
    return {op, f1, f2, f3};
  endfunction

  function automatic word_t enc_b(cond_t c, logic [8:0] off);
    return {4'hc, c, off};
  endfunction

  // reference rules for shifts and rotates
  function automatic word_t shift_ref(opcode_t op, word_t a, int amt);
    word_t r;
    r = a;
    for (int i = 0; i < amt; i++) begin
      case (op)
        op_sll: r = {r[14:0], 1'b0};
        op_sra: r = {r[15], r[15:1]};
        default: r = {r[0], r[15:1]};
      endcase
    end
    return r;
  endfunction

  // flags of x - y, then the condition on them
  function automatic logic branch_ref(cond_t c, word_t x, word_t y);
    int    diff;
    word_t d;
    logic  z, n, v;
    diff = int'($signed(x)) - int'($signed(y));
    d = x - y;
    z = (d == 16'h0000);
    n = d[15];
    v = (diff > 32767) || (diff < -32768);
    case (c)
      cond_ne: return !z;
      cond_eq: return z;
      cond_gt: return !z && !n;
      cond_lt: return n;
      cond_ge: return z || !n;
      cond_le: return n || z;
      cond_ov: return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic start_test(input string nm);
    name[ntests] = nm;
    nwords[ntests] = 0;
    nstores[ntests] = 0;
    ntests = ntests + 1;
  endtask

  task automatic emit(input word_t w);
    prog[ntests-1][nwords[ntests-1]] = w;
    nwords[ntests-1] = nwords[ntests-1] + 1;
  endtask

  task automatic expect_store(input word_t a, input word_t d);
    exp_addr[ntests-1][nstores[ntests-1]] = a;
    exp_data[ntests-1][nstores[ntests-1]] = d;
    nstores[ntests-1] = nstores[ntests-1] + 1;
  endtask

  // llb then lhb builds any value, back to back through the bypass
  task automatic load_reg(input logic [3:0] r, input word_t v);
    emit({4'ha, r, v[7:0]});
    emit({4'hb, r, v[15:8]});
  endtask

  // hlt is the last word, pc rests one word past it
  task automatic end_test();
    emit(16'hf000);
    exp_pc[ntests-1] = 16'(nwords[ntests-1] * 2);
  endtask

  task automatic build_tests();
    word_t x, y, c;
    cond_t cnd;
    for (int k = 0; k < 2; k++) begin
      x = next_rand();
      y = next_rand();
      start_test($sformatf("arith_%0d", k));
      load_reg(1, x);
      load_reg(2, y);
      emit(enc(op_add, 3, 1, 2));
      emit(enc(op_sub, 4, 1, 2));
      emit(enc(op_xor, 5, 3, 4));
      emit(enc(op_sw, 3, 0, 0));
      emit(enc(op_sw, 4, 0, 1));
      emit(enc(op_sw, 5, 0, 2));
      end_test();
      expect_store(16'h0000, x + y);
      expect_store(16'h0002, x - y);
      expect_store(16'h0004, (x + y) ^ (x - y));
    end
    // negative operand so sign fill and wrap show
    c = next_rand() | 16'h8000;
    start_test("shift_rotate");
    load_reg(1, c);
    emit(enc(op_sll, 2, 1, 0));
    emit(enc(op_sra, 3, 1, 7));
    emit(enc(op_ror, 4, 1, 15));
    emit(enc(op_sll, 5, 1, 15));
    emit(enc(op_sra, 6, 1, 15));
    emit(enc(op_ror, 7, 1, 7));
    for (int i = 0; i < 6; i++) begin
      emit(enc(op_sw, 4'(i + 2), 0, 4'(i)));
    end
    end_test();
    expect_store(16'h0000, shift_ref(op_sll, c, 0));
    expect_store(16'h0002, shift_ref(op_sra, c, 7));
    expect_store(16'h0004, shift_ref(op_ror, c, 15));
    expect_store(16'h0006, shift_ref(op_sll, c, 15));
    expect_store(16'h0008, shift_ref(op_sra, c, 15));
    expect_store(16'h000a, shift_ref(op_ror, c, 7));
    // base 0x20 at offset -2 lands on 0x1c
    x = next_rand();
    start_test("mem_r0");
    load_reg(1, 16'h0020);
    load_reg(2, x);
    emit(enc(op_sw, 2, 1, 4'he));
    emit(enc(op_lw, 3, 1, 4'he));
    emit(enc(op_sw, 3, 0, 3));
    emit(enc(op_add, 0, 2, 2));
    emit(enc(op_sw, 0, 0, 4));
    end_test();
    expect_store(16'h001c, x);
    expect_store(16'h0006, x);
    expect_store(16'h0008, 16'h0000);
    // one test per condition, taken target is word 10
    for (int k = 0; k < 8; k++) begin
      cnd = cond_t'(k);
      x = next_rand();
      y = next_rand();
      case (cnd)
        // equal operands
        cond_ne, cond_eq: y = x;
        // negative difference with no overflow while the xor result is positive
        cond_lt, cond_ge: begin
          x = {2'b00, x[13:0]};
          y = {2'b01, y[13:0]};
        end
        // positive difference with no overflow while the xor result is negative
        cond_gt, cond_le: begin
          x = {2'b00, x[13:0]};
          y = {2'b11, y[13:0]};
        end
        // difference overflows so a v written by the xor would show
        cond_ov: begin
          x = {2'b01, x[13:0]};
          y = {2'b10, y[13:0]};
        end
        default: ;
      endcase
      start_test($sformatf("branch_%s", cnd.name()));
      load_reg(1, x);
      load_reg(2, y);
      emit(enc(op_sub, 3, 1, 2));
      // xor may only move z, which agrees with the sub here
      emit(enc(op_xor, 4, 1, 2));
      emit(enc_b(cnd, 9'd3));
      emit(enc(op_sw, 1, 0, 0));
      emit(enc(op_sw, 1, 0, 1));
      emit(16'hf000);
      emit(enc(op_sw, 2, 0, 2));
      emit(16'hf000);
      if (branch_ref(cnd, x, y)) begin
        exp_pc[ntests-1] = 16'd24;
        expect_store(16'h0004, y);
      end else begin
        exp_pc[ntests-1] = 16'd20;
        expect_store(16'h0000, x);
        expect_store(16'h0002, x);
      end
    end
    start_test("br_pcs");
    emit(enc(op_pcs, 5, 0, 0));
    emit(enc(op_sw, 5, 0, 0));
    load_reg(6, 16'd14);
    emit(enc(op_br, 0, 6, 0));
    emit(enc(op_sw, 5, 0, 1));
    emit(enc(op_sw, 5, 0, 2));
    emit(enc(op_pcs, 7, 0, 0));
    emit(enc(op_sw, 7, 0, 3));
    end_test();
    expect_store(16'h0000, 16'd2);
    expect_store(16'h0006, 16'd16);
    // hlt in the shadow of a taken branch
    start_test("halt_flush");
    emit({4'ha, 4'd1, 8'h5a});
    emit(enc_b(cond_un, 9'd2));
    emit(16'hf000);
    emit(enc(op_sw, 1, 0, 0));
    emit(enc(op_sw, 1, 0, 1));
    end_test();
    expect_store(16'h0002, 16'h005a);
  endtask

  task automatic run_test(input int t);
    int n;
    int errs_before;
    errs_before = err_count;
    // program and data image go in before reset
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < nwords[t]) ? prog[t][i] : (16'hf000 | 16'(i));
      dmem[i] = 16'ha500 ^ (16'(i) * 16'h0103);
    end
    log_addr.delete();
    log_data.delete();
    @(posedge clk);
    #2;
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    do @(negedge clk); while (!hlt);
    // let a few cycles pass so late stores or a dropped hlt would show
    repeat (4) @(negedge clk);
    assert (hlt) else begin
      $display("error: hlt got %h expected 1", hlt);
      err_count++;
    end
    assert (pc == exp_pc[t]) else begin
      $display("error: pc got %h expected %h", pc, exp_pc[t]);
      err_count++;
    end
    n = log_addr.size();
    assert (n == nstores[t]) else begin
      $display("test %s: %0d stores seen where %0d were expected", name[t], n, nstores[t]);
      err_count++;
    end
    for (int i = 0; i < n && i < nstores[t]; i++) begin
      assert (log_addr[i] == exp_addr[t][i]) else begin
        $display("error: dmem_addr store %0d got %h expected %h", i, log_addr[i],
                 exp_addr[t][i]);
        err_count++;
      end
      assert (log_data[i] == exp_data[t][i]) else begin
        $display("error: dmem_wdata store %0d got %h expected %h", i, log_data[i],
                 exp_data[t][i]);
        err_count++;
      end
    end
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %s ok", name[t]);
    end else begin
      fail_count++;
      $display("test %s failed", name[t]);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    cycles = 0;
    cycle_limit = 0;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    ntests = 0;
    rng_state = 16'd36935;
    build_tests();
    for (int t = 0; t < ntests; t++) begin
      cycle_limit = cycle_limit + 4 * nwords[t] + 20;
    end
    for (int t = 0; t < ntests; t++) begin
      run_test(t);
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

  // operations the alu knows about
  // lw and sw never look at the alu result, they reuse alu_add
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_xor = 3'd2,
    alu_sll = 3'd3,
    alu_sra = 3'd4,
    alu_ror = 3'd5,
    alu_llb = 3'd6,
    alu_lhb = 3'd7
  } alu_op_t;

  // where the register write data comes from
  typedef enum logic [1:0] {
    wb_alu     = 2'd0,
    wb_mem     = 2'd1,
    wb_pc_next = 2'd2
  } wb_sel_t;

  // fetch either runs or sits frozen after a halt
  typedef enum logic {
    fs_running = 1'b0,
    fs_halted  = 1'b1
  } fetch_state_t;

endpackage

// File: decode_stage.sv
module decode_stage import isa_pkg::*, ctrl_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     if_valid,
  input  word_t    if_instr,
  input  word_t    if_pc,
  input  logic     redirect,
  input  logic     wb_en,
  input  reg_idx_t wb_idx,
  input  word_t    wb_data,
  output logic     stop_fetch,
  output logic     id_valid,
  output alu_op_t  id_op,
  output word_t    id_a,
  output word_t    id_b,
  output word_t    id_imm,
  output word_t    id_pc,
  output reg_idx_t id_rd,
  output wb_sel_t  id_wb_sel,
  output logic     id_wr_en,
  output logic     id_store,
  output logic     id_load,
  output flags_t   id_flag_en,
  output cond_t    id_cond,
  output logic     id_branch,
  output logic     id_branch_reg,
  output logic     id_halt
);

  // instruction fields
  opcode_t  opcode;
  reg_idx_t rd, rs, rt;
  shamt_t   shamt;
  byte_t    imm_byte;
  mem_off_t mem_off;
  br_off_t  br_off;

  // decoded controls before the pipeline register
  alu_op_t  op;
  wb_sel_t  wb_sel;
  word_t    imm;
  flags_t   flag_en;
  logic     wr_en, store, load, branch, branch_reg, halt;
  reg_idx_t rd_idx_a, rd_idx_b;
  word_t    rd_data_a, rd_data_b;

  assign opcode   = opcode_t'(if_instr[15:12]);
  assign rd       = if_instr[11:8];
  assign rs       = if_instr[7:4];
  assign rt       = if_instr[3:0];
  assign shamt    = if_instr[3:0];
  assign imm_byte = if_instr[7:0];
  assign mem_off  = if_instr[3:0];
  assign br_off   = if_instr[8:0];

  // llb/lhb modify rd in place, sw stores the rd register
  assign rd_idx_a = (opcode == op_llb || opcode == op_lhb) ? rd : rs;
  assign rd_idx_b = (opcode == op_sw) ? rd : rt;

  // a halt in decode freezes fetch right away
  assign stop_fetch = if_valid && (opcode == op_hlt);

  always_comb begin
    op         = alu_add;
    wb_sel     = wb_alu;
    imm        = '0;
    flag_en    = 3'b000;
    wr_en      = 1'b0;
    store      = 1'b0;
    load       = 1'b0;
    branch     = 1'b0;
    branch_reg = 1'b0;
    halt       = 1'b0;
    case (opcode)
      // arithmetic sets all three flags
      op_add: begin
        op      = alu_add;
        wr_en   = 1'b1;
        flag_en = 3'b111;
      end
      op_sub: begin
        op      = alu_sub;
        wr_en   = 1'b1;
        flag_en = 3'b111;
      end
      // logic and shifts touch z only
      op_xor: begin
        op      = alu_xor;
        wr_en   = 1'b1;
        flag_en = 3'b001;
      end
      op_sll, op_sra, op_ror: begin
        op      = (opcode == op_sll) ? alu_sll : (opcode == op_sra) ? alu_sra : alu_ror;
        imm     = {12'h000, shamt};
        wr_en   = 1'b1;
        flag_en = 3'b001;
      end
      op_lw: begin
        imm    = {{12{mem_off[3]}}, mem_off};
        load   = 1'b1;
        wr_en  = 1'b1;
        wb_sel = wb_mem;
      end
      op_sw: begin
        imm   = {{12{mem_off[3]}}, mem_off};
        store = 1'b1;
      end
      op_llb, op_lhb: begin
        op    = (opcode == op_llb) ? alu_llb : alu_lhb;
        imm   = {8'h00, imm_byte};
        wr_en = 1'b1;
      end
      op_b: begin
        imm    = {{7{br_off[8]}}, br_off};
        branch = 1'b1;
      end
      // br jumps to rs, read on port a
      op_br:  branch_reg = 1'b1;
      op_pcs: begin
        wr_en  = 1'b1;
        wb_sel = wb_pc_next;
      end
      op_hlt: halt = 1'b1;
      // unused opcodes fall through as no-ops
      default: ;
    endcase
  end

  register_file u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .wr_en     (wb_en),
    .wr_idx    (wb_idx),
    .wr_data   (wb_data),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  // valid drops when execute redirects
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= if_valid && !redirect;
    end
  end

  // everything else is qualified by id_valid in execute
  always_ff @(posedge clk) begin
    id_op         <= op;
    id_a          <= rd_data_a;
    id_b          <= rd_data_b;
    id_imm        <= imm;
    id_pc         <= if_pc;
    id_rd         <= rd;
    id_wb_sel     <= wb_sel;
    id_wr_en      <= wr_en;
    id_store      <= store;
    id_load       <= load;
    id_flag_en    <= flag_en;
    id_cond       <= cond_t'(if_instr[11:9]);
    id_branch     <= branch;
    id_branch_reg <= branch_reg;
    id_halt       <= halt;
  end

endmodule

// File: execute_stage.sv
module execute_stage import isa_pkg::*, ctrl_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     id_valid,
  input  alu_op_t  id_op,
  input  word_t    id_a,
  input  word_t    id_b,
  input  word_t    id_imm,
  input  word_t    id_pc,
  input  reg_idx_t id_rd,
  input  wb_sel_t  id_wb_sel,
  input  logic     id_wr_en,
  input  logic     id_store,
  input  logic     id_load,
  input  flags_t   id_flag_en,
  input  cond_t    id_cond,
  input  logic     id_branch,
  input  logic     id_branch_reg,
  input  logic     id_halt,
  input  word_t    dmem_rdata,
  output logic     redirect,
  output word_t    redirect_pc,
  output logic     wb_en,
  output reg_idx_t wb_idx,
  output word_t    wb_data,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  output logic     dmem_we,
  output logic     hlt
);

  word_t  alu_b, alu_result, pc_next, mem_addr, imm_x2;
  flags_t alu_flags, flags_q;
  logic   live, cond_met, mem_access, halted_q;

  // nothing commits once halted
  assign live = id_valid && !halted_q;

  // shifts and byte loads take their second operand from the instruction
  always_comb begin
    case (id_op)
      alu_sll, alu_sra, alu_ror, alu_llb, alu_lhb: alu_b = id_imm;
      default: alu_b = id_b;
    endcase
  end

  alu u_alu (
    .op     (id_op),
    .a      (id_a),
    .b      (alu_b),
    .result (alu_result),
    .flags  (alu_flags)
  );

  // only the enabled flag bits move
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags_q <= '0;
    end else if (live) begin
      for (int i = 0; i < 3; i++) begin
        if (id_flag_en[i]) begin
          flags_q[i] <= alu_flags[i];
        end
      end
    end
  end

  // conditions look at the flags left by older instructions
  always_comb begin
    case (id_cond)
      cond_ne: cond_met = !flags_q[flag_z];
      cond_eq: cond_met = flags_q[flag_z];
      cond_gt: cond_met = !flags_q[flag_z] && !flags_q[flag_n];
      cond_lt: cond_met = flags_q[flag_n];
      cond_ge: cond_met = flags_q[flag_z] || !flags_q[flag_n];
      cond_le: cond_met = flags_q[flag_n] || flags_q[flag_z];
      cond_ov: cond_met = flags_q[flag_v];
      default: cond_met = 1'b1;
    endcase
  end

  // offsets count half-words
  assign imm_x2  = {id_imm[14:0], 1'b0};
  assign pc_next = id_pc + 16'd2;

  // br is unconditional, b follows its condition
  assign redirect    = live && ((id_branch && cond_met) || id_branch_reg);
  assign redirect_pc = id_branch_reg ? id_a : pc_next + imm_x2;

  // word-aligned base plus scaled offset
  assign mem_addr   = {id_a[15:1], 1'b0} + imm_x2;
  assign mem_access = live && (id_load || id_store);
  assign dmem_addr  = mem_access ? mem_addr : '0;
  assign dmem_wdata = id_b;
  assign dmem_we    = live && id_store;

  // pcs writes the address after itself
  always_comb begin
    case (id_wb_sel)
      wb_mem:     wb_data = dmem_rdata;
      wb_pc_next: wb_data = pc_next;
      default:    wb_data = alu_result;
    endcase
  end

  assign wb_en  = live && id_wr_en;
  assign wb_idx = id_rd;

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted_q <= 1'b0;
    end else if (live && id_halt) begin
      halted_q <= 1'b1;
    end
  end

  assign hlt = halted_q;

endmodule

// File: fetch_stage.sv
module fetch_stage import isa_pkg::*, ctrl_pkg::*; #(
  parameter word_t reset_pc = 16'h0000
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  stop_fetch,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  word_t imem_data,
  output word_t imem_addr,
  output logic  if_valid,
  output word_t if_instr,
  output word_t if_pc
);

  fetch_state_t state_q, state_d;
  word_t pc_q, pc_d;
  logic  load_valid;

  // a redirect from execute wins over a halt sitting in decode
  // since that halt is on the wrong path and gets flushed
  always_comb begin
    state_d = state_q;
    pc_d    = pc_q + 16'd2;
    case (state_q)
      fs_running: begin
        if (redirect) begin
          pc_d = redirect_pc;
        end else if (stop_fetch) begin
          // hold the pc on the word after the hlt
          pc_d    = pc_q;
          state_d = fs_halted;
        end
      end
      default: begin
        // frozen until reset
        pc_d = pc_q;
      end
    endcase
  end

  // only a running fetch with no flush or stop hands decode a real instruction
  assign load_valid = (state_q == fs_running) && !redirect && !stop_fetch;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= fs_running;
      pc_q     <= reset_pc;
      if_valid <= 1'b0;
    end else begin
      state_q  <= state_d;
      pc_q     <= pc_d;
      if_valid <= load_valid;
    end
  end

  // instruction and its address, qualified by if_valid
  always_ff @(posedge clk) begin
    if_instr <= imem_data;
    if_pc    <= pc_q;
  end

  // imem answers in the same cycle
  assign imem_addr = pc_q;

endmodule

// File: isa_pkg.sv
package isa_pkg;

  // data words and byte addresses are both 16 bits
  typedef logic [15:0] word_t;

  // sixteen general registers, r0 reads as zero
  typedef logic [3:0] reg_idx_t;

  // immediate fields as they sit in the instruction word
  typedef logic [3:0] shamt_t;
  typedef logic [7:0] byte_t;
  typedef logic [3:0] mem_off_t;
  typedef logic [8:0] br_off_t;

  // instruction layout
  //   [15:12] opcode
  //   [11:8]  rd, or the store data register for sw
  //   [7:4]   rs
  //   [3:0]   rt, shift amount or memory offset
  //   llb/lhb keep their byte in [7:0]
  //   b keeps its condition in [11:9] and the offset in [8:0]
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_xor = 4'd2,
    op_sll = 4'd4,
    op_sra = 4'd5,
    op_ror = 4'd6,
    op_lw  = 4'd8,
    op_sw  = 4'd9,
    op_llb = 4'd10,
    op_lhb = 4'd11,
    op_b   = 4'd12,
    op_br  = 4'd13,
    op_pcs = 4'd14,
    op_hlt = 4'd15
  } opcode_t;

  // branch conditions, evaluated on the flag register
  typedef enum logic [2:0] {
    cond_ne = 3'd0,
    cond_eq = 3'd1,
    cond_gt = 3'd2,
    cond_lt = 3'd3,
    cond_ge = 3'd4,
    cond_le = 3'd5,
    cond_ov = 3'd6,
    cond_un = 3'd7
  } cond_t;

  // flag vector ordered v, n, z from msb to lsb
  typedef logic [2:0] flags_t;
  localparam int flag_v = 2;
  localparam int flag_n = 1;
  localparam int flag_z = 0;

endpackage

// File: register_file.sv
module register_file import isa_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rd_idx_a,
  input  reg_idx_t rd_idx_b,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data,
  output word_t    rd_data_a,
  output word_t    rd_data_b
);

  word_t regs [16];
  logic  wr_live;

  // writes to r0 are dropped so it stays zero
  assign wr_live = wr_en && (wr_idx != 4'd0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // write-through bypass
  // the instruction in execute writes back while its successor reads here
  always_comb begin
    rd_data_a = regs[rd_idx_a];
    rd_data_b = regs[rd_idx_b];
    if (wr_live && (wr_idx == rd_idx_a)) begin
      rd_data_a = wr_data;
    end
    if (wr_live && (wr_idx == rd_idx_b)) begin
      rd_data_b = wr_data;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module cpu_tb -o cpu_sim
out=$(./obj_dir/cpu_sim)
echo "$out"
if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
